// ==== logic/glb_params.svh ====
`ifndef GLB_PARAMS_SVH
`define GLB_PARAMS_SVH

// stream word coming from the array
`define GLB_CGRA_DATA_WIDTH 16

// one bank line, four stream words
`define GLB_BANK_DATA_WIDTH 64

// byte address into a 4 KiB bank
`define GLB_ADDR_WIDTH 12
`define GLB_BANK_BYTE_OFFSET 3

// store descriptor queue
`define GLB_QUEUE_DEPTH 4
`define GLB_MAX_NUM_WORDS_WIDTH 10

// host register port
`define GLB_CFG_ADDR_WIDTH 4
`define GLB_CFG_DATA_WIDTH 32

`endif

// ==== logic/glb_pkg.sv ====
`default_nettype none

`include "glb_params.svh"

package glb_pkg;

    // one store descriptor, 23 bits
    typedef struct packed {
        logic                                valid;
        logic [`GLB_ADDR_WIDTH-1:0]          start_addr;
        logic [`GLB_MAX_NUM_WORDS_WIDTH-1:0] num_words;
    } glb_dma_header_t;

endpackage

`default_nettype wire

// ==== logic/glb_wr_if.sv ====
`default_nettype none

`include "glb_params.svh"

// bank write packet, one line per cycle with wr_en high
interface glb_wr_if ();

    logic                                wr_en;
    logic [`GLB_BANK_DATA_WIDTH/8-1:0]   wr_strb;
    // line-aligned byte address
    logic [`GLB_ADDR_WIDTH-1:0]          wr_addr;
    logic [`GLB_BANK_DATA_WIDTH-1:0]     wr_data;

    modport dma (output wr_en, wr_strb, wr_addr, wr_data);
    modport bank (input wr_en, wr_strb, wr_addr, wr_data);

endinterface

`default_nettype wire

// ==== logic/glb_dma_cfg_if.sv ====
`default_nettype none

`include "glb_params.svh"

interface glb_dma_cfg_if import glb_pkg::*; ();

    logic                        dma_on;
    logic                        auto_on;
    glb_dma_header_t             header [`GLB_QUEUE_DEPTH];
    // one-cycle pulse per entry when the dma takes it
    logic [`GLB_QUEUE_DEPTH-1:0] invalidate_pulse;

    modport cfg (
        output dma_on, auto_on, header,
        input  invalidate_pulse
    );

    modport dma (
        input  dma_on, auto_on, header,
        output invalidate_pulse
    );

endinterface

`default_nettype wire

// ==== logic/glb_store_cfg.sv ====
`default_nettype none

`include "glb_params.svh"

module glb_store_cfg import glb_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           clk_en,
    input  logic                           cfg_wr_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  logic [`GLB_CFG_DATA_WIDTH-1:0] cfg_wdata,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_rd_addr,
    output logic [`GLB_CFG_DATA_WIDTH-1:0] cfg_rdata,
    glb_dma_cfg_if.cfg                     cfg_if
);

    localparam int AW = `GLB_CFG_ADDR_WIDTH;
    localparam int DEPTH = `GLB_QUEUE_DEPTH;
    localparam int ENTRY_BASE = 1;
    localparam int VALID_BASE = ENTRY_BASE + DEPTH;
    localparam int NUM_WORDS_LSB = 16;
    localparam int NUM_WORDS_MSB = NUM_WORDS_LSB + `GLB_MAX_NUM_WORDS_WIDTH - 1;

    logic            dma_on;
    logic            auto_on;
    glb_dma_header_t queue [DEPTH];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dma_on <= 1'b0;
            auto_on <= 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                queue[i] <= '0;
            end
        end else if (clk_en) begin
            if (cfg_wr_en && cfg_addr == '0) begin
                dma_on <= cfg_wdata[0];
                auto_on <= cfg_wdata[1];
            end
            for (int i = 0; i < DEPTH; i++) begin
                if (cfg_if.invalidate_pulse[i]) begin
                    queue[i].valid <= 1'b0;
                end
                // host writes come last so they win over the dma
                if (cfg_wr_en && cfg_addr == AW'(ENTRY_BASE + i)) begin
                    queue[i].start_addr <= cfg_wdata[`GLB_ADDR_WIDTH-1:0];
                    queue[i].num_words <= cfg_wdata[NUM_WORDS_MSB:NUM_WORDS_LSB];
                    queue[i].valid <= 1'b0;
                end
                if (cfg_wr_en && cfg_addr == AW'(VALID_BASE + i)) begin
                    queue[i].valid <= cfg_wdata[0];
                end
            end
        end
    end

    // register readback
    always_comb begin
        cfg_rdata = '0;
        if (cfg_rd_addr == '0) begin
            cfg_rdata[0] = dma_on;
            cfg_rdata[1] = auto_on;
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (cfg_rd_addr == AW'(ENTRY_BASE + i)) begin
                cfg_rdata[`GLB_ADDR_WIDTH-1:0] = queue[i].start_addr;
                cfg_rdata[NUM_WORDS_MSB:NUM_WORDS_LSB] = queue[i].num_words;
            end
            if (cfg_rd_addr == AW'(VALID_BASE + i)) begin
                cfg_rdata[0] = queue[i].valid;
            end
        end
    end

    assign cfg_if.dma_on = dma_on;
    assign cfg_if.auto_on = auto_on;
    assign cfg_if.header = queue;

    // host must keep the bits above the word count clear
    a_num_words_fits: assert property (@(posedge clk) disable iff (reset)
        clk_en && cfg_wr_en && cfg_addr >= AW'(ENTRY_BASE) && cfg_addr < AW'(VALID_BASE)
        |-> cfg_wdata[`GLB_CFG_DATA_WIDTH-1:NUM_WORDS_MSB+1] == '0)
        else $error("num_words wider than its field: 0x%08h", cfg_wdata);

endmodule

`default_nettype wire

// ==== logic/glb_store_dma.sv ====
`default_nettype none

`include "glb_params.svh"

module glb_store_dma import glb_pkg::*; (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            clk_en,
    input  logic [`GLB_CGRA_DATA_WIDTH-1:0] stream_data,
    input  logic                            stream_valid,
    output logic                            stream_in_done_pulse,
    glb_dma_cfg_if.dma                      cfg_if,
    glb_wr_if.dma                           wr_if
);

    localparam int DEPTH = `GLB_QUEUE_DEPTH;
    localparam int QW = $clog2(DEPTH);
    localparam int AW = `GLB_ADDR_WIDTH;
    localparam int NW = `GLB_MAX_NUM_WORDS_WIDTH;
    localparam int OFS = `GLB_BANK_BYTE_OFFSET;
    localparam int WW = `GLB_CGRA_DATA_WIDTH;
    localparam int LW = `GLB_BANK_DATA_WIDTH;
    localparam int WORD_BYTES = WW / 8;
    localparam int WB_W = $clog2(WORD_BYTES);
    localparam int SW = $clog2(LW / WW);

    // READY..ACC3 must stay consecutive, the slot index is taken from it
    typedef enum logic [2:0] {OFF, IDLE, READY, ACC1, ACC2, ACC3, ACC4, DONE} state_t;

    state_t            state;
    state_t            next_state;
    state_t            fill_next;
    logic [SW-1:0]     slot;

    logic [LW-1:0]     cache_data;
    logic [LW-1:0]     next_cache_data;
    logic [LW/8-1:0]   cache_strb;
    logic [LW/8-1:0]   next_cache_strb;
    // address of the line being packed
    logic [AW-1:0]     cur_addr;
    logic [AW-1:0]     next_cur_addr;
    logic [NW-1:0]     num_cnt;
    logic [NW-1:0]     next_num_cnt;

    glb_dma_header_t   header_int [DEPTH];
    glb_dma_header_t   sel_hdr;
    logic [DEPTH-1:0]  valid_now;
    logic [DEPTH-1:0]  valid_d1;
    logic [DEPTH-1:0]  validate_pulse;
    logic [DEPTH-1:0]  invalidate_pulse;
    logic [QW-1:0]     q_sel_cnt_r;
    logic [QW-1:0]     q_sel;
    logic              start;
    logic              line_write;
    logic              done_d1;

    // descriptor capture on rising valid
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            valid_now[i] = cfg_if.header[i].valid;
        end
    end

    assign validate_pulse = valid_now & ~valid_d1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_d1 <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                header_int[i] <= '0;
            end
        end else if (clk_en) begin
            valid_d1 <= valid_now;
            for (int i = 0; i < DEPTH; i++) begin
                if (validate_pulse[i]) begin
                    header_int[i] <= cfg_if.header[i];
                end else if (invalidate_pulse[i]) begin
                    header_int[i].valid <= 1'b0;
                end
            end
        end
    end

    // queue entry select, manual mode pins entry 0
    assign q_sel = cfg_if.auto_on ? q_sel_cnt_r : '0;
    assign sel_hdr = header_int[q_sel];
    assign start = (state == IDLE) && cfg_if.dma_on && sel_hdr.valid
                   && (sel_hdr.num_words != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            invalidate_pulse <= '0;
            q_sel_cnt_r <= '0;
        end else if (clk_en) begin
            invalidate_pulse <= '0;
            if (start) begin
                invalidate_pulse[q_sel] <= 1'b1;
            end
            if (!cfg_if.auto_on) begin
                q_sel_cnt_r <= '0;
            end else if (start) begin
                q_sel_cnt_r <= (q_sel_cnt_r == QW'(DEPTH - 1)) ? '0 : q_sel_cnt_r + 1'b1;
            end
        end
    end

    assign cfg_if.invalidate_pulse = invalidate_pulse;

    // slot filled by the current state and the state after it
    assign slot = SW'(state - READY);
    assign fill_next = state_t'(state + 3'd1);

    always_comb begin
        next_state = state;
        next_cache_data = cache_data;
        next_cache_strb = cache_strb;
        next_cur_addr = cur_addr;
        next_num_cnt = num_cnt;
        case (state)
            OFF: begin
                if (cfg_if.dma_on) begin
                    next_state = IDLE;
                end
            end
            IDLE: begin
                next_cache_data = '0;
                next_cache_strb = '0;
                if (start) begin
                    next_cur_addr = {sel_hdr.start_addr[AW-1:OFS], {OFS{1'b0}}};
                    next_num_cnt = sel_hdr.num_words;
                    // first slot from the word bits, byte bit ignored
                    next_state = state_t'(READY + sel_hdr.start_addr[OFS-1:WB_W]);
                end
            end
            READY, ACC1, ACC2, ACC3: begin
                if (num_cnt == '0) begin
                    next_state = DONE;
                end else if (stream_valid) begin
                    next_cache_data[slot*WW +: WW] = stream_data;
                    next_cache_strb[slot*WORD_BYTES +: WORD_BYTES] = '1;
                    next_num_cnt = num_cnt - 1'b1;
                    next_state = fill_next;
                end
            end
            ACC4: begin
                if (num_cnt == '0) begin
                    next_state = DONE;
                end else begin
                    // full line goes out this cycle
                    next_cur_addr = cur_addr + AW'(LW / 8);
                    next_cache_data = '0;
                    next_cache_strb = '0;
                    if (stream_valid) begin
                        next_cache_data[WW-1:0] = stream_data;
                        next_cache_strb[WORD_BYTES-1:0] = '1;
                        next_num_cnt = num_cnt - 1'b1;
                        next_state = ACC1;
                    end else begin
                        next_state = READY;
                    end
                end
            end
            DONE: begin
                next_state = IDLE;
            end
            default: begin
                next_state = OFF;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= OFF;
            cache_strb <= '0;
            cur_addr <= '0;
            num_cnt <= '0;
        end else if (clk_en) begin
            state <= cfg_if.dma_on ? next_state : OFF;
            cache_strb <= next_cache_strb;
            cur_addr <= next_cur_addr;
            num_cnt <= next_num_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en) begin
            cache_data <= next_cache_data;
        end
    end

    // write packet
    assign line_write = (state == DONE) || (state == ACC4 && num_cnt != '0);
    assign wr_if.wr_en = line_write;
    assign wr_if.wr_strb = line_write ? cache_strb : '0;
    assign wr_if.wr_data = line_write ? cache_data : '0;
    assign wr_if.wr_addr = cur_addr;

    // end of descriptor
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_d1 <= 1'b0;
        end else if (clk_en) begin
            done_d1 <= (state == DONE);
        end
    end

    assign stream_in_done_pulse = (state == DONE) && !done_d1;

    a_one_invalidate: assert property (@(posedge clk) disable iff (reset)
        $onehot0(invalidate_pulse))
        else $error("several invalidate pulses: %b", invalidate_pulse);

    a_wr_strb_set: assert property (@(posedge clk) disable iff (reset)
        wr_if.wr_en |-> wr_if.wr_strb != '0)
        else $error("bank write with empty strobe");

    a_done_single: assert property (@(posedge clk) disable iff (reset)
        clk_en && stream_in_done_pulse |=> !stream_in_done_pulse)
        else $error("done pulse held for two cycles");

endmodule

`default_nettype wire

// ==== logic/glb_bank.sv ====
`default_nettype none

`include "glb_params.svh"

module glb_bank (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            clk_en,
    input  logic                            rd_en,
    input  logic [`GLB_ADDR_WIDTH-1:0]      rd_addr,
    output logic [`GLB_BANK_DATA_WIDTH-1:0] rd_data,
    glb_wr_if.bank                          wr_if
);

    localparam int AW = `GLB_ADDR_WIDTH;
    localparam int OFS = `GLB_BANK_BYTE_OFFSET;
    localparam int LW = `GLB_BANK_DATA_WIDTH;
    localparam int LINE_W = AW - OFS;
    localparam int DEPTH = 1 << LINE_W;

    logic [LW-1:0]     mem [DEPTH];
    logic [LINE_W-1:0] wr_line;
    logic [LINE_W-1:0] rd_line;

    assign wr_line = wr_if.wr_addr[AW-1:OFS];
    assign rd_line = rd_addr[AW-1:OFS];

    // byte lanes enabled by the strobe
    always_ff @(posedge clk) begin
        if (clk_en && wr_if.wr_en) begin
            for (int b = 0; b < LW / 8; b++) begin
                if (wr_if.wr_strb[b]) begin
                    mem[wr_line][b*8 +: 8] <= wr_if.wr_data[b*8 +: 8];
                end
            end
        end
    end

    // read during write returns the old line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data <= '0;
        end else if (clk_en && rd_en) begin
            rd_data <= mem[rd_line];
        end
    end

    a_wr_addr_aligned: assert property (@(posedge clk) disable iff (reset)
        clk_en && wr_if.wr_en |-> wr_if.wr_addr[OFS-1:0] == '0)
        else $error("unaligned bank write address 0x%03h", wr_if.wr_addr);

endmodule

`default_nettype wire

// ==== logic/glb_store_top.sv ====
`default_nettype none

`include "glb_params.svh"

module glb_store_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            clk_en,
    input  logic                            cfg_wr_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0]  cfg_addr,
    input  logic [`GLB_CFG_DATA_WIDTH-1:0]  cfg_wdata,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0]  cfg_rd_addr,
    output logic [`GLB_CFG_DATA_WIDTH-1:0]  cfg_rdata,
    input  logic [`GLB_CGRA_DATA_WIDTH-1:0] stream_data,
    input  logic                            stream_valid,
    output logic                            stream_in_done_pulse,
    input  logic                            rd_en,
    input  logic [`GLB_ADDR_WIDTH-1:0]      rd_addr,
    output logic [`GLB_BANK_DATA_WIDTH-1:0] rd_data
);

    glb_wr_if      wr_if ();
    glb_dma_cfg_if cfg_if ();

    // host registers and descriptor queue
    glb_store_cfg u_cfg (
        .clk         (clk),
        .reset       (reset),
        .clk_en      (clk_en),
        .cfg_wr_en   (cfg_wr_en),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rd_addr (cfg_rd_addr),
        .cfg_rdata   (cfg_rdata),
        .cfg_if      (cfg_if.cfg)
    );

    glb_store_dma u_dma (
        .clk                  (clk),
        .reset                (reset),
        .clk_en               (clk_en),
        .stream_data          (stream_data),
        .stream_valid         (stream_valid),
        .stream_in_done_pulse (stream_in_done_pulse),
        .cfg_if               (cfg_if.dma),
        .wr_if                (wr_if.dma)
    );

    glb_bank u_bank (
        .clk     (clk),
        .reset   (reset),
        .clk_en  (clk_en),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_if   (wr_if.bank)
    );

endmodule

`default_nettype wire

// ==== testbench/glb_store_tb.sv ====
`default_nettype none

`include "glb_params.svh"

module glb_store_tb;

    localparam int TOTAL_WORDS = 8 + 28 + 24 + 18 + 10;
    localparam int NUM_TESTS = 5;
    localparam int CYCLE_LIMIT = 20 * TOTAL_WORDS + 200 * NUM_TESTS;

    logic                            clk;
    logic                            reset;
    logic                            clk_en;
    logic                            cfg_wr_en;
    logic [`GLB_CFG_ADDR_WIDTH-1:0]  cfg_addr;
    logic [`GLB_CFG_DATA_WIDTH-1:0]  cfg_wdata;
    logic [`GLB_CFG_ADDR_WIDTH-1:0]  cfg_rd_addr;
    logic [`GLB_CFG_DATA_WIDTH-1:0]  cfg_rdata;
    logic [`GLB_CGRA_DATA_WIDTH-1:0] stream_data;
    logic                            stream_valid;
    logic                            stream_in_done_pulse;
    logic                            rd_en;
    logic [`GLB_ADDR_WIDTH-1:0]      rd_addr;
    logic [`GLB_BANK_DATA_WIDTH-1:0] rd_data;

    // reference bank, one byte per address
    logic [7:0]  model_mem [4096];
    bit          known [4096];
    logic [15:0] data_buf [32];
    logic [15:0] lfsr;
    int          error_count;
    int          test_errors_at_start;
    int          tests_run;
    int          tests_failed;
    int          starts_expected;
    int          done_seen;
    int          cycle_count = 0;

    logic        chk_q;
    logic [11:0] chk_addr;
    logic [63:0] exp_q;
    logic [63:0] mask_q;

    glb_store_top DUT (
        .clk                  (clk),
        .reset                (reset),
        .clk_en               (clk_en),
        .cfg_wr_en            (cfg_wr_en),
        .cfg_addr             (cfg_addr),
        .cfg_wdata            (cfg_wdata),
        .cfg_rd_addr          (cfg_rd_addr),
        .cfg_rdata            (cfg_rdata),
        .stream_data          (stream_data),
        .stream_valid         (stream_valid),
        .stream_in_done_pulse (stream_in_done_pulse),
        .rd_en                (rd_en),
        .rd_addr              (rd_addr),
        .rd_data              (rd_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    // galois lfsr, one step per bit
    function automatic logic [15:0] lfsr_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [63:0] model_line(input logic [11:0] a);
        logic [63:0] line;
        for (int b = 0; b < 8; b++) begin
            line[b*8 +: 8] = model_mem[{a[11:3], 3'(b)}];
        end
        return line;
    endfunction

    function automatic logic [63:0] line_mask(input logic [11:0] a);
        logic [63:0] mask;
        for (int b = 0; b < 8; b++) begin
            mask[b*8 +: 8] = {8{known[{a[11:3], 3'(b)}]}};
        end
        return mask;
    endfunction

    function automatic logic [31:0] entry_word(input logic [11:0] addr, input int n);
        return {6'd0, 10'(n), 4'd0, addr};
    endfunction

    // expected line captured on the edge that samples rd_en
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            chk_q <= 1'b0;
            chk_addr <= '0;
            exp_q <= '0;
            mask_q <= '0;
        end else begin
            chk_q <= rd_en;
            chk_addr <= rd_addr;
            exp_q <= model_line(rd_addr);
            mask_q <= line_mask(rd_addr);
        end
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            done_seen <= 0;
        end else if (stream_in_done_pulse) begin
            done_seen <= done_seen + 1;
        end
    end

    a_rd_data: assert property (@(posedge clk) disable iff (reset)
        chk_q |-> ((rd_data ^ exp_q) & mask_q) == '0)
        else begin
            error_count++;
            $display("[ERROR] rd_data line 0x%03h: got 0x%016h expected 0x%016h",
                     $sampled(chk_addr), $sampled(rd_data) & $sampled(mask_q),
                     $sampled(exp_q) & $sampled(mask_q));
        end

    a_done_expected: assert property (@(posedge clk) disable iff (reset)
        stream_in_done_pulse |-> done_seen < starts_expected)
        else begin
            error_count++;
            $display("done pulse with no descriptor left to finish");
        end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        cfg_wr_en = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        next_cycle();
        cfg_wr_en = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        cfg_rd_addr = addr;
        #1;
        data = cfg_rdata;
        next_cycle();
    endtask

    task automatic expect_reg(input logic [3:0] addr, input logic [31:0] expected);
        logic [31:0] v;
        read_reg(addr, v);
        assert (v == expected)
            else begin
                error_count++;
                $display("[ERROR] cfg_rdata reg %0d: got 0x%08h expected 0x%08h",
                         addr, v, expected);
            end
    endtask

    task automatic fill_words(input int off, input int n);
        for (int k = 0; k < n; k++) begin
            data_buf[off + k] = lfsr_bits(16);
        end
    endtask

    // wait until the entry's valid bit clears
    task automatic wait_started(input int entry);
        logic [31:0] v;
        v = 32'd1;
        while (v[0]) begin
            read_reg(4'(5 + entry), v);
        end
    endtask

    task automatic wait_done_count(input int target);
        while (done_seen < target) begin
            next_cycle();
        end
    endtask

    task automatic stream_words(input logic [11:0] addr, input int off, input int n,
                                input bit gaps, input bit apply);
        logic [1:0] gap;
        int         a;
        for (int k = 0; k < n; k++) begin
            if (gaps) begin
                gap = 2'(lfsr_bits(2));
                stream_valid = 1'b0;
                repeat (gap) next_cycle();
            end
            stream_valid = 1'b1;
            stream_data = data_buf[off + k];
            if (apply) begin
                a = int'({addr[11:1], 1'b0}) + 2 * k;
                model_mem[a] = data_buf[off + k][7:0];
                model_mem[a + 1] = data_buf[off + k][15:8];
                known[a] = 1'b1;
                known[a + 1] = 1'b1;
            end
            next_cycle();
        end
        stream_valid = 1'b0;
    endtask

    task automatic run_store(input int entry, input logic [11:0] addr, input int off,
                             input int n, input bit gaps);
        write_reg(4'(1 + entry), entry_word(addr, n));
        write_reg(4'(5 + entry), 32'd1);
        starts_expected++;
        wait_started(entry);
        stream_words(addr, off, n, gaps, 1'b1);
        wait_done_count(starts_expected);
    endtask

    task automatic check_lines(input logic [11:0] lo, input logic [11:0] hi);
        for (int a = int'(lo) & ~7; a <= int'(hi); a += 8) begin
            rd_en = 1'b1;
            rd_addr = 12'(a);
            next_cycle();
        end
        rd_en = 1'b0;
        next_cycle();
    endtask

    task automatic begin_test();
        test_errors_at_start = error_count;
    endtask

    task automatic end_test(input string name);
        assert (done_seen == starts_expected)
            else begin
                error_count++;
                $display("[ERROR] done pulses: got 0x%0h expected 0x%0h",
                         done_seen, starts_expected);
            end
        tests_run++;
        if (error_count != test_errors_at_start) begin
            tests_failed++;
            $display("test %0d %s: FAILED", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    initial begin
        int base;
        clk = 1'b0;
        reset = 1'b1;
        clk_en = 1'b1;
        cfg_wr_en = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        cfg_rd_addr = '0;
        stream_data = '0;
        stream_valid = 1'b0;
        rd_en = 1'b0;
        rd_addr = '0;
        lfsr = 16'd40364;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        starts_expected = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();

        begin_test();
        write_reg(4'd0, 32'd1);
        fill_words(0, 8);
        run_store(0, 12'h040, 0, 8, 1'b0);
        check_lines(12'h040, 12'h04F);
        end_test("aligned store");

        // prefill, then partial lines starting at slot 1 and slot 3
        begin_test();
        fill_words(0, 16);
        run_store(0, 12'h100, 0, 16, 1'b0);
        fill_words(0, 9);
        run_store(0, 12'h102, 0, 9, 1'b0);
        fill_words(0, 3);
        run_store(0, 12'h117, 0, 3, 1'b0);
        check_lines(12'h100, 12'h11F);
        end_test("unaligned store strobes");

        begin_test();
        fill_words(0, 12);
        run_store(0, 12'h184, 0, 12, 1'b0);
        run_store(0, 12'h1C4, 0, 12, 1'b1);
        check_lines(12'h180, 12'h1DF);
        end_test("stream gaps");

        begin_test();
        write_reg(4'd0, 32'd3);
        fill_words(0, 5);
        fill_words(8, 6);
        fill_words(16, 7);
        write_reg(4'd1, entry_word(12'h0A0, 5));
        write_reg(4'd2, entry_word(12'h0C6, 6));
        write_reg(4'd3, entry_word(12'h0E2, 7));
        base = starts_expected;
        for (int i = 0; i < 3; i++) begin
            write_reg(4'(5 + i), 32'd1);
        end
        starts_expected += 3;
        wait_started(0);
        expect_reg(4'd6, 32'd1);
        stream_words(12'h0A0, 0, 5, 1'b0, 1'b1);
        wait_done_count(base + 1);
        wait_started(1);
        expect_reg(4'd7, 32'd1);
        stream_words(12'h0C6, 8, 6, 1'b1, 1'b1);
        wait_done_count(base + 2);
        wait_started(2);
        stream_words(12'h0E2, 16, 7, 1'b0, 1'b1);
        wait_done_count(base + 3);
        check_lines(12'h0A0, 12'h0EF);
        end_test("auto queue order");

        // manual mode, dma off, then a zero-word entry
        begin_test();
        write_reg(4'd0, 32'd1);
        write_reg(4'd2, entry_word(12'h280, 4));
        write_reg(4'd6, 32'd1);
        fill_words(0, 4);
        run_store(0, 12'h200, 0, 4, 1'b0);
        repeat (8) next_cycle();
        expect_reg(4'd6, 32'd1);
        write_reg(4'd0, 32'd0);
        expect_reg(4'd0, 32'd0);
        // pending descriptor over the same lines while the dma is off
        write_reg(4'd1, entry_word(12'h200, 6));
        write_reg(4'd5, 32'd1);
        fill_words(8, 6);
        stream_words(12'h200, 8, 6, 1'b0, 1'b0);
        repeat (8) next_cycle();
        expect_reg(4'd5, 32'd1);
        check_lines(12'h200, 12'h207);
        write_reg(4'd1, entry_word(12'h300, 0));
        write_reg(4'd5, 32'd1);
        write_reg(4'd0, 32'd1);
        repeat (10) next_cycle();
        expect_reg(4'd5, 32'd1);
        expect_reg(4'd1, entry_word(12'h300, 0));
        end_test("manual mode and dma off");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/glb_pkg.sv
logic/glb_wr_if.sv
logic/glb_dma_cfg_if.sv
logic/glb_store_cfg.sv
logic/glb_store_dma.sv
logic/glb_bank.sv
logic/glb_store_top.sv
testbench/glb_store_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= glb_store_tb
RTL_TOP   ?= glb_store_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(wildcard logic/*.sv logic/*.svh testbench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "Finished with errors" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
